/* src/rv_defs.svh */
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

`define XLEN      32            // Data and address width
`define REG_COUNT 32            // Architectural registers
`define RESET_PC  32'h0000_0000 // First fetch address

`endif

/* src/rv_pkg.sv */
`include "rv_defs.svh"

package rv_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [4:0]       reg_addr_t;
    typedef logic [6:0]       opcode_t;
    typedef logic [3:0]       alu_op_t;

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXECUTE,
        MEMORY,
        WRITEBACK
    } core_state_t;

    // Major opcodes of the supported subset
    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;

    localparam alu_op_t ALU_ADD  = 4'b0000;
    localparam alu_op_t ALU_SUB  = 4'b0001;
    localparam alu_op_t ALU_SLL  = 4'b0010;
    localparam alu_op_t ALU_SLT  = 4'b0100;
    localparam alu_op_t ALU_SLTU = 4'b0110;
    localparam alu_op_t ALU_XOR  = 4'b1000;
    localparam alu_op_t ALU_SRL  = 4'b1010;
    localparam alu_op_t ALU_SRA  = 4'b1011;
    localparam alu_op_t ALU_OR   = 4'b1100;
    localparam alu_op_t ALU_AND  = 4'b1110;

endpackage

/* src/control_unit.sv */
module control_unit (
    input  rv_pkg::opcode_t opcode,
    input  logic [2:0]      func3,
    input  logic [6:0]      func7,
    output logic            alu_src,        // Immediate as second operand
    output logic            branch_control, // Conditional branch
    output logic            write_enable,   // Register write-back
    output rv_pkg::alu_op_t alu_opra,       // ALU operation code
    output logic            mem_reg,        // Write back memory data
    output logic            mem_read,
    output logic            mem_write
);

    import rv_pkg::*;

    alu_op_t arith_op;   // Operation for register and immediate forms
    logic    arith_legal;

    // Register and immediate forms share one func3 map
    always_comb begin
        arith_legal = 1'b1;
        arith_op    = ALU_ADD;
        case (func3)
            3'b000: begin
                if (opcode == OP_REG && func7 == 7'b0100000) begin
                    arith_op = ALU_SUB;
                end else if (opcode == OP_REG && func7 != 7'b0000000) begin
                    arith_legal = 1'b0;
                end
            end
            3'b001: arith_op = ALU_SLL;
            3'b010: arith_op = ALU_SLT;
            3'b011: arith_op = ALU_SLTU;
            3'b100: arith_op = ALU_XOR;
            3'b101: begin
                if (func7 == 7'b0000000) begin
                    arith_op = ALU_SRL;
                end else if (func7 == 7'b0100000) begin
                    arith_op = ALU_SRA;
                end else begin
                    arith_legal = 1'b0;
                end
            end
            3'b110: arith_op = ALU_OR;
            3'b111: arith_op = ALU_AND;
            default: arith_legal = 1'b0;
        endcase
    end

    always_comb begin
        // Anything not matched below is a no-op
        alu_src        = 1'b0;
        branch_control = 1'b0;
        write_enable   = 1'b0;
        alu_opra       = ALU_ADD;
        mem_reg        = 1'b0;
        mem_read       = 1'b0;
        mem_write      = 1'b0;
        case (opcode)
            OP_REG, OP_IMM: begin
                if (arith_legal) begin
                    alu_src      = (opcode == OP_IMM);
                    write_enable = 1'b1;
                    alu_opra     = arith_op;
                end
            end
            OP_LOAD: begin
                alu_src      = 1'b1; // Base plus offset
                write_enable = 1'b1;
                mem_reg      = 1'b1;
                mem_read     = 1'b1;
            end
            OP_STORE: begin
                alu_src   = 1'b1;
                mem_write = 1'b1;
            end
            OP_BRANCH: begin
                branch_control = 1'b1;
                alu_opra       = ALU_SUB; // Equal operands give zero
            end
            default: ;
        endcase
    end

endmodule

/* src/core_fsm.sv */
module core_fsm (
    input  logic            clk,
    input  logic            rst_n,
    input  rv_pkg::opcode_t opcode,
    input  logic            mem_read,        // Decoded load
    input  logic            mem_write,       // Decoded store
    output logic            ir_load,
    output logic            operand_load,
    output logic            result_load,
    output logic            mem_read_pulse,
    output logic            mem_write_pulse,
    output logic            wb_phase,
    output logic            pc_step
);

    import rv_pkg::*;

    core_state_t state;
    core_state_t state_next;
    logic        is_branch;

    assign is_branch = (opcode == OP_BRANCH);

    always_comb begin
        state_next = state;
        case (state)
            FETCH:     state_next = DECODE;
            DECODE:    state_next = EXECUTE;
            EXECUTE: begin
                if (is_branch) begin
                    state_next = FETCH;
                end else if (mem_read || mem_write) begin
                    state_next = MEMORY;
                end else begin
                    state_next = WRITEBACK;
                end
            end
            MEMORY:    state_next = mem_read ? WRITEBACK : FETCH; // Stores end here
            WRITEBACK: state_next = FETCH;
            default:   state_next = FETCH;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= FETCH;
        end else begin
            state <= state_next;
        end
    end

    assign ir_load         = (state == FETCH);
    assign operand_load    = (state == DECODE);
    assign result_load     = (state == EXECUTE);
    assign mem_read_pulse  = (state == MEMORY) && mem_read;
    assign mem_write_pulse = (state == MEMORY) && mem_write;
    assign wb_phase        = (state == WRITEBACK);
    // pc moves in the last phase of every instruction
    assign pc_step = wb_phase || ((state == EXECUTE) && is_branch) || mem_write_pulse;

    assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_read_pulse && mem_write_pulse));

endmodule

/* src/program_counter.sv */
`include "rv_defs.svh"

module program_counter (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          step,
    input  logic          take_branch,
    input  rv_pkg::word_t branch_offset, // Relative to current pc
    output rv_pkg::word_t pc
);

    import rv_pkg::*;

    word_t next_pc;

    assign next_pc = pc + (take_branch ? branch_offset : word_t'(4));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= `RESET_PC;
        end else if (step) begin
            pc <= next_pc;
        end
    end

    // Fetch addresses stay on word boundaries
    assert property (@(posedge clk) disable iff (!rst_n)
        pc[1:0] == 2'b00);

endmodule

/* src/reg_file.sv */
`include "rv_defs.svh"

module reg_file (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::reg_addr_t rs1_addr,
    input  rv_pkg::reg_addr_t rs2_addr,
    input  rv_pkg::reg_addr_t rd_addr,
    input  rv_pkg::word_t     rd_wdata,
    input  logic              rd_we,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data
);

    import rv_pkg::*;

    word_t regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && rd_addr != '0) begin
            regs[rd_addr] <= rd_wdata; // x0 never written
        end
    end

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    assert property (@(posedge clk) disable iff (!rst_n)
        (rs1_addr == '0) |-> (rs1_data == '0)); // x0 keeps its reset value

    assert property (@(posedge clk) disable iff (!rst_n)
        (rs2_addr == '0) |-> (rs2_data == '0));

endmodule

/* src/alu.sv */
module alu (
    input  rv_pkg::alu_op_t op,
    input  rv_pkg::word_t   a,
    input  rv_pkg::word_t   b,
    output rv_pkg::word_t   result,
    output logic            zero    // Used by beq
);

    import rv_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = word_t'($signed(a) < $signed(b));
            ALU_SLTU: result = word_t'(a < b);
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = word_t'($signed(a) >>> shamt); // Sign fill
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

/* src/imm_gen.sv */
module imm_gen (
    input  rv_pkg::word_t instr,
    output rv_pkg::word_t imm
);

    import rv_pkg::*;

    opcode_t opcode;

    assign opcode = instr[6:0];

    always_comb begin
        case (opcode)
            OP_STORE: begin // S layout
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            OP_BRANCH: begin // B layout, halfword offset
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            default: begin
                imm = {{20{instr[31]}}, instr[31:20]}; // I layout
            end
        endcase
    end

endmodule

/* src/rv_core.sv */
module rv_core (
    input  logic          clk,
    input  logic          rst_n,
    input  rv_pkg::word_t instr,
    input  rv_pkg::word_t mem_rdata,
    output rv_pkg::word_t instr_addr,
    output rv_pkg::word_t mem_addr,
    output rv_pkg::word_t mem_wdata,
    output logic          mem_read,
    output logic          mem_write
);

    import rv_pkg::*;

    word_t   ir;          // Instruction register
    word_t   a_reg;       // Operand registers
    word_t   b_reg;
    word_t   imm_reg;
    word_t   result_reg;
    word_t   mdr;         // Load data
    word_t   pc;
    word_t   rs1_data;
    word_t   rs2_data;
    word_t   imm;
    word_t   alu_b;
    word_t   alu_result;
    word_t   rd_wdata;
    alu_op_t alu_opra;
    logic    alu_src;
    logic    branch_control;
    logic    write_enable;
    logic    mem_reg;
    logic    dec_mem_read;
    logic    dec_mem_write;
    logic    ir_load;
    logic    operand_load;
    logic    result_load;
    logic    wb_phase;
    logic    pc_step;
    logic    alu_zero;
    logic    take_branch;

    control_unit u_control (
        .opcode         (ir[6:0]),
        .func3          (ir[14:12]),
        .func7          (ir[31:25]),
        .alu_src        (alu_src),
        .branch_control (branch_control),
        .write_enable   (write_enable),
        .alu_opra       (alu_opra),
        .mem_reg        (mem_reg),
        .mem_read       (dec_mem_read),
        .mem_write      (dec_mem_write)
    );

    core_fsm u_fsm (
        .clk             (clk),
        .rst_n           (rst_n),
        .opcode          (ir[6:0]),
        .mem_read        (dec_mem_read),
        .mem_write       (dec_mem_write),
        .ir_load         (ir_load),
        .operand_load    (operand_load),
        .result_load     (result_load),
        .mem_read_pulse  (mem_read),
        .mem_write_pulse (mem_write),
        .wb_phase        (wb_phase),
        .pc_step         (pc_step)
    );

    // Only sampled by the pc during EXECUTE of a branch
    assign take_branch = branch_control && alu_zero;

    program_counter u_pc (
        .clk           (clk),
        .rst_n         (rst_n),
        .step          (pc_step),
        .take_branch   (take_branch),
        .branch_offset (imm_reg),
        .pc            (pc)
    );

    reg_file u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (ir[19:15]),
        .rs2_addr (ir[24:20]),
        .rd_addr  (ir[11:7]),
        .rd_wdata (rd_wdata),
        .rd_we    (wb_phase && write_enable),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    imm_gen u_imm (
        .instr (ir),
        .imm   (imm)
    );

    assign alu_b = alu_src ? imm_reg : b_reg;

    alu u_alu (
        .op     (alu_opra),
        .a      (a_reg),
        .b      (alu_b),
        .result (alu_result),
        .zero   (alu_zero)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ir <= '0;
        end else if (ir_load) begin
            ir <= instr;
        end
    end

    always_ff @(posedge clk) begin
        if (operand_load) begin
            a_reg   <= rs1_data;
            b_reg   <= rs2_data;
            imm_reg <= imm;
        end
        if (result_load) begin
            result_reg <= alu_result;
        end
        if (mem_read) begin
            mdr <= mem_rdata; // End of MEMORY
        end
    end

    assign rd_wdata   = mem_reg ? mdr : result_reg;
    assign instr_addr = pc;
    assign mem_addr   = result_reg;
    assign mem_wdata  = b_reg;

endmodule

/* tb/tb_clock.sv */
module tb_clock (
    output logic clk
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk; // 20 ns period
        end
    end

endmodule

/* tb/rv_core_tb.sv */
`include "rv_defs.svh"

module rv_core_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import rv_pkg::*;

    localparam int PROG_LEN  = 120;             // Body plus the closing stores
    localparam int BODY_LEN  = PROG_LEN - 7;
    localparam int CYCLE_MAX = 5 * PROG_LEN + 20;
    localparam logic [`XLEN-1:0] HALT_ADDR = PROG_LEN * 4;

    logic             clk;
    logic             rst_n;
    logic [`XLEN-1:0] instr;
    logic [`XLEN-1:0] mem_rdata;
    logic [`XLEN-1:0] instr_addr;
    logic [`XLEN-1:0] mem_addr;
    logic [`XLEN-1:0] mem_wdata;
    logic             mem_read;
    logic             mem_write;

    logic [`XLEN-1:0] imem [128];
    logic [`XLEN-1:0] dmem [64];
    logic [`XLEN-1:0] model_mem [64];
    logic [`XLEN-1:0] model_regs [32];
    logic [`XLEN-1:0] exp_pc [$];               // pc after each instruction
    logic [`XLEN-1:0] exp_ld_addr [$];
    logic [`XLEN-1:0] exp_st_addr [$];
    logic [`XLEN-1:0] exp_st_data [$];
    logic [`XLEN-1:0] last_addr;
    logic [15:0]      lfsr;
    int               errors;
    int               checks;
    int               cycles;

    tb_clock u_clock (
        .clk (clk)
    );

    rv_core dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr      (instr),
        .mem_rdata  (mem_rdata),
        .instr_addr (instr_addr),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_read   (mem_read),
        .mem_write  (mem_write)
    );

    assign instr     = imem[instr_addr[8:2]];
    assign mem_rdata = dmem[mem_addr[7:2]];

    always @(posedge clk) begin
        if (mem_write) begin
            dmem[mem_addr[7:2]] = mem_wdata; // Word written on the store edge
        end
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr  = lfsr_step(lfsr);
            value = {value[30:0], lfsr[0]};
        end
        return value;
    endfunction

    function automatic logic [31:0] enc_branch(input logic [12:0] off, input logic [4:0] rs2,
                                               input logic [4:0] rs1);
        return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        logic [31:0] r;
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = {31'd0, $signed(a) < $signed(b)};
            3'd3: r = {31'd0, a < b};
            3'd4: r = a ^ b;
            3'd5: begin
                if (alt) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    task automatic build_program();
        logic [3:0]  kind;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        int          skip;
        for (int i = 0; i < 64; i++) begin
            dmem[i]      = take_bits(32); // Preset load data
            model_mem[i] = dmem[i];
        end
        for (int i = 0; i < BODY_LEN; i++) begin
            kind = 4'(take_bits(4));
            f3   = 3'(take_bits(3));
            rd   = 5'(1 + take_bits(3) % 7); // x1 to x7
            rs1  = 5'(take_bits(3));
            rs2  = 5'(take_bits(3));
            imm  = 12'(take_bits(12));
            if (kind < 4'd5) begin
                f7 = ((f3 == 3'd0 || f3 == 3'd5) && take_bits(1) == 32'd1) ? 7'h20 : 7'h00;
                imem[i] = {f7, rs2, rs1, f3, rd, OP_REG};
            end else if (kind < 4'd10) begin
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    f7  = (f3 == 3'd5 && take_bits(1) == 32'd1) ? 7'h20 : 7'h00;
                    imm = {f7, imm[4:0]};        // Shift amount 0 to 31
                end
                imem[i] = {imm, rs1, f3, rd, OP_IMM};
            end else if (kind < 4'd12) begin
                imm     = {4'd0, 6'(take_bits(6)), 2'd0}; // x0 base keeps it in range
                imem[i] = {imm, 5'd0, 3'b010, rd, OP_LOAD};
            end else if (kind == 4'd12) begin
                imm     = {4'd0, 6'(take_bits(6)), 2'd0};
                imem[i] = {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], OP_STORE};
            end else if (kind < 4'd15) begin
                if (take_bits(1) == 32'd1) begin
                    rs2 = rs1;                   // Taken branch
                end
                skip = 1 + int'(take_bits(2) % 3);
                if (i + skip + 1 > BODY_LEN) begin
                    skip = BODY_LEN - i - 1;
                end
                imem[i] = enc_branch(13'((skip + 1) * 4), rs2, rs1);
            end else if (take_bits(1) == 32'd1) begin
                imem[i] = {imm, rs1, f3, 5'd0, OP_IMM}; // Write to x0
            end else begin
                imem[i] = {25'(take_bits(25)), 7'b0110111}; // lui, outside the subset
            end
        end
        for (int r = 1; r < 8; r++) begin
            imem[BODY_LEN + r - 1] = {7'd0, 5'(r), 5'd0, 3'b010, 5'(4 * r), OP_STORE};
        end
        for (int i = PROG_LEN; i < 128; i++) begin
            imem[i] = enc_branch(13'((PROG_LEN - i) * 4), 5'd0, 5'd0); // Back to halt word
        end
    endtask

    task automatic run_model();
        logic [31:0] pc;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        logic [31:0] imm_i;
        logic [31:0] res;
        logic [31:0] next_pc;
        logic        wr;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        pc = `RESET_PC;
        while (pc != HALT_ADDR) begin
            w       = imem[pc[8:2]];
            a       = model_regs[w[19:15]];
            b       = model_regs[w[24:20]];
            imm_i   = {{20{w[31]}}, w[31:20]};
            next_pc = pc + 4;
            wr      = 1'b1;
            res     = '0;
            case (w[6:0])
                OP_REG: res = alu_model(w[14:12], w[30], a, b);
                OP_IMM: res = alu_model(w[14:12], w[30] && w[14:12] == 3'd5, a, imm_i);
                OP_LOAD: begin
                    addr = a + imm_i;
                    res  = model_mem[addr[7:2]];
                    exp_ld_addr.push_back(addr);
                end
                OP_STORE: begin
                    wr   = 1'b0;
                    addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
                    model_mem[addr[7:2]] = b;
                    exp_st_addr.push_back(addr);
                    exp_st_data.push_back(b);
                end
                OP_BRANCH: begin
                    wr = 1'b0;
                    if (a == b) begin
                        next_pc = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                    end
                end
                default: wr = 1'b0;
            endcase
            if (wr && w[11:7] != 5'd0) begin
                model_regs[w[11:7]] = res;
            end
            pc = next_pc;
            exp_pc.push_back(pc);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Sampled mid-cycle, away from the clock edge
    task automatic observe();
        if (instr_addr != last_addr) begin
            if (exp_pc.size() == 0) begin
                errors++;
                $display("Error: instr_addr moved to %h past the end of the program", instr_addr);
            end else begin
                check_value("pc_trace", exp_pc.pop_front(), instr_addr);
            end
            last_addr = instr_addr;
        end
        if (mem_read) begin
            if (exp_ld_addr.size() == 0) begin
                errors++;
                $display("Error: load from %h that the program does not make", mem_addr);
            end else begin
                check_value("load_addr", exp_ld_addr.pop_front(), mem_addr);
            end
        end
        if (mem_write) begin
            if (exp_st_addr.size() == 0) begin
                errors++;
                $display("Error: store to %h that the program does not make", mem_addr);
            end else begin
                check_value("store_addr", exp_st_addr.pop_front(), mem_addr);
                check_value("store_data", exp_st_data.pop_front(), mem_wdata);
            end
        end
    endtask

    initial begin
        rst_n  = 1'b0;
        lfsr   = 16'd51660;
        errors = 0;
        checks = 0;
        cycles = 0;
        build_program();
        run_model();
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        check_value("reset_pc", `RESET_PC, instr_addr);
        check_value("reset_mem_write", 32'd0, {31'd0, mem_write});
        check_value("reset_mem_read", 32'd0, {31'd0, mem_read});
        last_addr = instr_addr;
        while (instr_addr != HALT_ADDR && cycles < CYCLE_MAX) begin
            @(negedge clk);
            cycles++;
            observe();
        end
        if (instr_addr != HALT_ADDR) begin
            errors++;
            $display("Error: timeout, the core did not finish the program in %0d cycles",
                     CYCLE_MAX);
        end
        if (exp_pc.size() != 0 || exp_ld_addr.size() != 0 || exp_st_addr.size() != 0) begin
            errors++;
            $display("Error: %0d pc steps, %0d loads and %0d stores were never seen",
                     exp_pc.size(), exp_ld_addr.size(), exp_st_addr.size());
        end
        $display("Run complete after %0d cycles: %0d checks, %0d errors", cycles, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+src
src/rv_pkg.sv
src/control_unit.sv
src/core_fsm.sv
src/program_counter.sv
src/reg_file.sv
src/alu.sv
src/imm_gen.sv
src/rv_core.sv
tb/tb_clock.sv
tb/rv_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the rv_core regression with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module rv_core_tb -f all.f -o rv_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/rv_core_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Regression passed"; then
    exit 0
fi
echo "Simulation did not report a pass"
exit 1
